// File: verilog/dma_consts.svh
// ========================================
// DMA mover constants
// Widths, feature header, accelerator ID and version
// ========================================
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// CSR data width, one 64-bit register per 8 bytes
`define DMA_CSR_W       64

// Memory word address, data word and length widths
`define DMA_MEM_ADDR_W  16
`define DMA_WORD_W      64
`define DMA_LEN_W       16

// Device feature header
// Type [63:60] is 1 (AFU), bit 40 marks end of the feature list
`define DMA_DFH         64'h1000_0100_0000_0000

// Accelerator ID, low word at GUID_L and high word at GUID_H
`define DMA_AFU_ID      128'h5e8a_31c7_0d94_4b26_a1f3_9c62_7e05_d8b4

// Reserved words of the feature header block
`define DMA_RSVD_1      64'hdead_beef_abcd_ef01
`define DMA_RSVD_2      64'hbadd_c0de_fedc_ba10

// Major 1, minor 2
`define DMA_TYPE_VERSION 64'h0000_0000_0001_0002

`endif

// File: verilog/dma_csr_pkg.sv
// ========================================
// DMA mover register map types
// ========================================
`include "dma_consts.svh"

package dma_csr_pkg;

    // One CSR word
    typedef logic [`DMA_CSR_W-1:0] t_csr_data;

    // Register index, byte address bits 7 to 3
    typedef logic [4:0] t_csr_index;

    // ========================================
    // Register offsets
    // ========================================
    typedef enum t_csr_index {
        // Feature header block, read only
        DMA_DFH          = 5'd0,
        DMA_GUID_L       = 5'd1,
        DMA_GUID_H       = 5'd2,
        DMA_RSVD_1       = 5'd3,
        DMA_RSVD_2       = 5'd4,
        // Copy descriptor, shared by both engines
        DMA_SRC_ADDR     = 5'd5,
        DMA_DEST_ADDR    = 5'd6,
        DMA_LENGTH       = 5'd7,
        // Command and completion
        DMA_CONTROL      = 5'd8,
        DMA_STATUS       = 5'd9,
        DMA_SEQ_NUM      = 5'd10,
        DMA_TYPE_VERSION = 5'd11
    } t_csr_reg;

    // Control register bits
    localparam int CTRL_START_D2H = 0;
    localparam int CTRL_START_H2D = 1;
    // Clears the sticky done and reject bits
    localparam int CTRL_CLEAR     = 2;

endpackage

// File: verilog/dma_xfer_pkg.sv
// ========================================
// DMA mover transfer types
// ========================================
`include "dma_consts.svh"

package dma_xfer_pkg;

    // Word address on the memory ports
    typedef logic [`DMA_MEM_ADDR_W-1:0] t_mem_addr;
    // One data word
    typedef logic [`DMA_WORD_W-1:0]     t_word;
    // Copy length in words
    typedef logic [`DMA_LEN_W-1:0]      t_length;

    // Completion counter
    typedef logic [31:0] t_seq_num;

    // ========================================
    // Status word layout
    // ========================================
    typedef logic [4:0] t_status;

    // Busy bits follow the engines
    localparam int STAT_D2H_BUSY = 0;
    localparam int STAT_H2D_BUSY = 1;
    // Sticky until cleared through the control register
    localparam int STAT_D2H_DONE = 2;
    localparam int STAT_H2D_DONE = 3;
    localparam int STAT_REJECT   = 4;

    // Copy engine FSM
    typedef enum logic [1:0] {
        ENG_IDLE,
        // Issuing reads
        ENG_RUN,
        // Last write in flight
        ENG_DRAIN
    } t_engine_state;

endpackage

// File: verilog/dma_engine_if.sv
// ========================================
// Descriptor, start and status of one engine
// ========================================
`timescale 1ns/1ps

interface dma_engine_if
    import dma_xfer_pkg::*;
();

    // One-cycle start pulse and the descriptor it picks up
    logic      start;
    t_mem_addr src_addr;
    t_mem_addr dest_addr;
    t_length   length;

    // Busy is a level, done and reject are one-cycle pulses
    logic      busy;
    logic      done;
    logic      reject;

    // Register block side
    modport ctrl (output start, src_addr, dest_addr, length);

    // Copy engine side
    modport engine (
        input  start, src_addr, dest_addr, length,
        output busy, done, reject
    );

    // Status merger only watches the engine
    modport monitor (input busy, done, reject);

endinterface

// File: verilog/dma_csr_mgr.sv
// ========================================
// AXI-lite register block of the DMA mover
// Holds the descriptor, decodes control writes into start pulses
// ========================================
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_csr_mgr
    import dma_csr_pkg::*;
    import dma_xfer_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // AXI-lite write address, data and response
    input  logic       awvalid,
    output logic       awready,
    input  logic [7:0] awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  t_csr_data  wdata,
    output logic       bvalid,
    input  logic       bready,
    // AXI-lite read address and data
    input  logic       arvalid,
    output logic       arready,
    input  logic [7:0] araddr,
    output logic       rvalid,
    input  logic       rready,
    output t_csr_data  rdata,
    // Engine command ports
    dma_engine_if.ctrl d2h,
    dma_engine_if.ctrl h2d,
    // From the status merger
    input  t_status    status,
    input  t_seq_num   seq_num,
    output logic       clear_done
);

    localparam logic [127:0] AFU_ID = `DMA_AFU_ID;

    // Held requests, one read and one write at a time
    logic       ar_held;
    logic [7:0] ar_addr;
    logic       aw_held;
    logic [7:0] aw_addr;
    logic       w_held;
    t_csr_data  w_data;

    logic       is_read;
    logic       is_write;
    t_csr_index rd_index;
    t_csr_index wr_index;
    t_csr_data  rd_word;

    // Descriptor and last control value
    t_mem_addr  src_addr;
    t_mem_addr  dest_addr;
    t_length    length;
    logic [2:0] control;
    logic       d2h_start;
    logic       h2d_start;

    // A held read is answered on the next edge
    assign is_read  = ar_held;
    // A write is applied once address and data are both held
    assign is_write = aw_held && w_held;

    // Byte addresses, low 3 bits select a byte inside the 64-bit word
    assign rd_index = ar_addr[7:3];
    assign wr_index = aw_addr[7:3];

    assign arready = !ar_held && !rvalid;
    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;

    // ========================================
    // Request capture
    // ========================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ar_held <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (is_read) begin
                ar_held <= 1'b0;
            end else if (arvalid && arready) begin
                ar_held <= 1'b1;
            end
            // Address and data may arrive in either order
            if (is_write) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end else begin
                if (awvalid && awready) begin
                    aw_held <= 1'b1;
                end
                if (wvalid && wready) begin
                    w_held <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_addr <= araddr;
        end
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
        end
    end

    // ========================================
    // Read decode and response
    // ========================================
    always_comb begin
        case (rd_index)
            DMA_DFH:          rd_word = `DMA_DFH;
            DMA_GUID_L:       rd_word = AFU_ID[63:0];
            DMA_GUID_H:       rd_word = AFU_ID[127:64];
            DMA_RSVD_1:       rd_word = `DMA_RSVD_1;
            DMA_RSVD_2:       rd_word = `DMA_RSVD_2;
            DMA_SRC_ADDR:     rd_word = t_csr_data'(src_addr);
            DMA_DEST_ADDR:    rd_word = t_csr_data'(dest_addr);
            DMA_LENGTH:       rd_word = t_csr_data'(length);
            DMA_CONTROL:      rd_word = t_csr_data'(control);
            DMA_STATUS:       rd_word = t_csr_data'(status);
            DMA_SEQ_NUM:      rd_word = t_csr_data'(seq_num);
            DMA_TYPE_VERSION: rd_word = `DMA_TYPE_VERSION;
            // Unmapped offsets read as zero
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (is_read) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // Response rises on the same edge the write is applied
            if (is_write) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_read) begin
            rdata <= rd_word;
        end
    end

    // ========================================
    // Register writes and command pulses
    // ========================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            src_addr   <= '0;
            dest_addr  <= '0;
            length     <= '0;
            control    <= '0;
            d2h_start  <= 1'b0;
            h2d_start  <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            // Pulses last for the cycle after the write edge
            d2h_start  <= is_write && wr_index == DMA_CONTROL && w_data[CTRL_START_D2H];
            h2d_start  <= is_write && wr_index == DMA_CONTROL && w_data[CTRL_START_H2D];
            clear_done <= is_write && wr_index == DMA_CONTROL && w_data[CTRL_CLEAR];
            if (is_write) begin
                case (wr_index)
                    DMA_SRC_ADDR:  src_addr  <= w_data[`DMA_MEM_ADDR_W-1:0];
                    DMA_DEST_ADDR: dest_addr <= w_data[`DMA_MEM_ADDR_W-1:0];
                    DMA_LENGTH:    length    <= w_data[`DMA_LEN_W-1:0];
                    DMA_CONTROL:   control   <= w_data[2:0];
                    // Writes to read-only or unmapped offsets are dropped
                    default: ;
                endcase
            end
        end
    end

    // Both engines share one descriptor, latched by each at its start
    assign d2h.start     = d2h_start;
    assign d2h.src_addr  = src_addr;
    assign d2h.dest_addr = dest_addr;
    assign d2h.length    = length;
    assign h2d.start     = h2d_start;
    assign h2d.src_addr  = src_addr;
    assign h2d.dest_addr = dest_addr;
    assign h2d.length    = length;

    // No write is applied while the previous response is still owed
    a_no_write_during_b: assert property (
        @(posedge clk) disable iff (!reset_n) !(is_write && bvalid)
    );

endmodule

// File: verilog/dma_copy_engine.sv
// ========================================
// Word-copy engine, read port to write port
// ========================================
`timescale 1ns/1ps

module dma_copy_engine
    import dma_xfer_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    dma_engine_if.engine eng,
    // Read port, data one cycle after the strobe
    output logic         rd_en,
    output t_mem_addr    rd_addr,
    input  t_word        rd_data,
    // Write port
    output logic         wr_en,
    output t_mem_addr    wr_addr,
    output t_word        wr_data
);

    t_engine_state state;
    // Reads still to issue after the current one
    t_length       rd_left;
    // Read issued last cycle, its data is on rd_data now
    logic          rd_valid_q;
    t_mem_addr     wr_addr_q;
    logic          busy;
    logic          done;
    logic          reject;

    assign eng.busy   = busy;
    assign eng.done   = done;
    assign eng.reject = reject;

    // Write k goes out in the cycle its read data returns
    assign wr_en   = rd_valid_q;
    assign wr_addr = wr_addr_q;
    assign wr_data = rd_data;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= ENG_IDLE;
            busy       <= 1'b0;
            done       <= 1'b0;
            reject     <= 1'b0;
            rd_en      <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            done       <= 1'b0;
            rd_valid_q <= rd_en;
            // Start while a copy is running is refused
            reject     <= eng.start && state != ENG_IDLE;
            case (state)
                ENG_IDLE: begin
                    if (eng.start) begin
                        if (eng.length == '0) begin
                            // Empty copy completes at once
                            done <= 1'b1;
                        end else begin
                            state <= ENG_RUN;
                            busy  <= 1'b1;
                            rd_en <= 1'b1;
                        end
                    end
                end
                ENG_RUN: begin
                    // Last read issued this cycle
                    if (rd_left == '0) begin
                        rd_en <= 1'b0;
                        state <= ENG_DRAIN;
                    end
                end
                ENG_DRAIN: begin
                    // Final write is on the port now
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= ENG_IDLE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // ========================================
    // Address counters
    // ========================================
    always_ff @(posedge clk) begin
        if (state == ENG_IDLE && eng.start) begin
            rd_addr   <= eng.src_addr;
            rd_left   <= eng.length - 1'b1;
            wr_addr_q <= eng.dest_addr;
        end else begin
            if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1'b1;
            end
            if (rd_valid_q) begin
                wr_addr_q <= wr_addr_q + 1'b1;
            end
        end
    end

    // Memory traffic only while the engine reports busy
    a_traffic_when_busy: assert property (
        @(posedge clk) disable iff (!reset_n) (rd_en || wr_en) |-> busy
    );

endmodule

// File: verilog/dma_status_merge.sv
// ========================================
// Merges engine events into status and count
// ========================================
`timescale 1ns/1ps

module dma_status_merge
    import dma_xfer_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    dma_engine_if.monitor d2h,
    dma_engine_if.monitor h2d,
    input  logic          clear_done,
    output t_status       status,
    output t_seq_num      seq_num
);

    // Both engines may finish on the same cycle
    logic [1:0] done_count;

    assign done_count = 2'(d2h.done) + 2'(h2d.done);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            status  <= '0;
            seq_num <= '0;
        end else begin
            status[STAT_D2H_BUSY] <= d2h.busy;
            status[STAT_H2D_BUSY] <= h2d.busy;
            // Sticky bits, a new event wins over a clear
            status[STAT_D2H_DONE] <= d2h.done || (status[STAT_D2H_DONE] && !clear_done);
            status[STAT_H2D_DONE] <= h2d.done || (status[STAT_H2D_DONE] && !clear_done);
            status[STAT_REJECT]   <= d2h.reject || h2d.reject
                                     || (status[STAT_REJECT] && !clear_done);
            seq_num <= seq_num + t_seq_num'(done_count);
        end
    end

    // Done comes from an engine that has already dropped busy
    a_done_when_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(d2h.done && d2h.busy) && !(h2d.done && h2d.busy)
    );

endmodule

// File: verilog/dma_mover_top.sv
// ========================================
// DMA mover top level
// Register block, two copy engines and status merger
// ========================================
`timescale 1ns/1ps

module dma_mover_top
    import dma_csr_pkg::*;
    import dma_xfer_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // AXI-lite register port
    input  logic       awvalid,
    output logic       awready,
    input  logic [7:0] awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  t_csr_data  wdata,
    output logic       bvalid,
    input  logic       bready,
    input  logic       arvalid,
    output logic       arready,
    input  logic [7:0] araddr,
    output logic       rvalid,
    input  logic       rready,
    output t_csr_data  rdata,
    // Host memory
    output logic       host_rd_en,
    output t_mem_addr  host_rd_addr,
    input  t_word      host_rd_data,
    output logic       host_wr_en,
    output t_mem_addr  host_wr_addr,
    output t_word      host_wr_data,
    // DDR memory
    output logic       ddr_rd_en,
    output t_mem_addr  ddr_rd_addr,
    input  t_word      ddr_rd_data,
    output logic       ddr_wr_en,
    output t_mem_addr  ddr_wr_addr,
    output t_word      ddr_wr_data
);

    t_status  status;
    t_seq_num seq_num;
    logic     clear_done;

    dma_engine_if d2h_if ();
    dma_engine_if h2d_if ();

    dma_csr_mgr i_csr_mgr (
        .clk        (clk),
        .reset_n    (reset_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .d2h        (d2h_if.ctrl),
        .h2d        (h2d_if.ctrl),
        .status     (status),
        .seq_num    (seq_num),
        .clear_done (clear_done)
    );

    // DDR read port to host write port
    dma_copy_engine i_d2h (
        .clk     (clk),
        .reset_n (reset_n),
        .eng     (d2h_if.engine),
        .rd_en   (ddr_rd_en),
        .rd_addr (ddr_rd_addr),
        .rd_data (ddr_rd_data),
        .wr_en   (host_wr_en),
        .wr_addr (host_wr_addr),
        .wr_data (host_wr_data)
    );

    // Host read port to DDR write port
    dma_copy_engine i_h2d (
        .clk     (clk),
        .reset_n (reset_n),
        .eng     (h2d_if.engine),
        .rd_en   (host_rd_en),
        .rd_addr (host_rd_addr),
        .rd_data (host_rd_data),
        .wr_en   (ddr_wr_en),
        .wr_addr (ddr_wr_addr),
        .wr_data (ddr_wr_data)
    );

    dma_status_merge i_status_merge (
        .clk        (clk),
        .reset_n    (reset_n),
        .d2h        (d2h_if.monitor),
        .h2d        (h2d_if.monitor),
        .clear_done (clear_done),
        .status     (status),
        .seq_num    (seq_num)
    );

endmodule

// File: tests/tb_dma_mover.sv
// ========================================
// DMA mover testbench
// Directed register and copy tests against host and DDR memory models
// ========================================
`timescale 1ns/1ps
`include "dma_consts.svh"

module tb_dma_mover
    import dma_csr_pkg::*;
    import dma_xfer_pkg::*;
();

    localparam logic [127:0] AFU_ID = `DMA_AFU_ID;
    // Upper bound of register accesses over all tests, polls included
    localparam int unsigned CSR_ACCESSES = 100;
    localparam int unsigned REJECT_LEN   = 40;

    // Copy regions, source and destination never overlap
    localparam t_mem_addr D2H_SRC   = 16'h1000;
    localparam t_mem_addr D2H_DEST  = 16'h2000;
    localparam t_mem_addr PAIR_SRC  = 16'h3000;
    localparam t_mem_addr PAIR_DEST = 16'h4000;
    localparam t_mem_addr REJ_SRC   = 16'h5000;
    localparam t_mem_addr REJ_DEST  = 16'h6000;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       awvalid;
    logic       awready;
    logic [7:0] awaddr;
    logic       wvalid;
    logic       wready;
    t_csr_data  wdata;
    logic       bvalid;
    logic       bready;
    logic       arvalid;
    logic       arready;
    logic [7:0] araddr;
    logic       rvalid;
    logic       rready;
    t_csr_data  rdata;
    logic       host_rd_en;
    t_mem_addr  host_rd_addr;
    t_word      host_rd_data = '0;
    logic       host_wr_en;
    t_mem_addr  host_wr_addr;
    t_word      host_wr_data;
    logic       ddr_rd_en;
    t_mem_addr  ddr_rd_addr;
    t_word      ddr_rd_data = '0;
    logic       ddr_wr_en;
    t_mem_addr  ddr_wr_addr;
    t_word      ddr_wr_data;

    // Memory models and their write counters
    t_word       host_mem [0:65535];
    t_word       ddr_mem  [0:65535];
    int unsigned host_wr_count = 0;
    int unsigned ddr_wr_count  = 0;
    logic        host_rd_req;
    t_mem_addr   host_rd_at;
    logic        ddr_rd_req;
    t_mem_addr   ddr_rd_at;

    int unsigned len_single;
    int unsigned len_pair;
    t_seq_num    exp_seq = '0;

    // 4 ns clock
    always #2 clk = ~clk;

    dma_mover_top i_dma_mover_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .bvalid       (bvalid),
        .bready       (bready),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .ddr_rd_en    (ddr_rd_en),
        .ddr_rd_addr  (ddr_rd_addr),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_wr_en    (ddr_wr_en),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_wr_data  (ddr_wr_data)
    );

    // ========================================
    // Memory models
    // ========================================
    // Requests taken at the edge, read data driven just after it
    always @(posedge clk) begin
        host_rd_req = host_rd_en;
        host_rd_at  = host_rd_addr;
        if (host_wr_en) begin
            host_mem[host_wr_addr] = host_wr_data;
            host_wr_count++;
        end
        #0.5;
        if (host_rd_req) begin
            host_rd_data = host_mem[host_rd_at];
        end
    end

    always @(posedge clk) begin
        ddr_rd_req = ddr_rd_en;
        ddr_rd_at  = ddr_rd_addr;
        if (ddr_wr_en) begin
            ddr_mem[ddr_wr_addr] = ddr_wr_data;
            ddr_wr_count++;
        end
        #0.5;
        if (ddr_rd_req) begin
            ddr_rd_data = ddr_mem[ddr_rd_at];
        end
    end

    // ========================================
    // Helpers and checks
    // ========================================
    task automatic report_failure();
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic watchdog(input int unsigned cycles);
        repeat (cycles) @(posedge clk);
        $display("The run timed out after %0d cycles before all tests finished", cycles);
        report_failure();
    endtask

    // Inputs change half a nanosecond after the edge
    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check_csr(input string name, input t_csr_data got, input t_csr_data exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input t_word got, input t_word exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_status(input string name, input t_status got, input t_status exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    // ========================================
    // AXI-lite access
    // ========================================
    task automatic csr_write(input t_csr_index idx, input t_csr_data data, input int hold);
        logic aw_hs;
        logic w_hs;
        awvalid = 1'b1;
        awaddr  = {idx, 3'b000};
        wvalid  = 1'b1;
        wdata   = data;
        // Each valid drops after its own handshake edge
        while (awvalid || wvalid) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            step();
            if (aw_hs) begin
                awvalid = 1'b0;
            end
            if (w_hs) begin
                wvalid = 1'b0;
            end
        end
        while (!bvalid) begin
            step();
        end
        // Response must outlast a slow bready
        repeat (hold) begin
            step();
            if (!bvalid) begin
                $display("Write response for register %0d vanished while bready was low", idx);
                report_failure();
            end
        end
        bready = 1'b1;
        step();
        bready = 1'b0;
    endtask

    task automatic csr_read(input t_csr_index idx, output t_csr_data data, input int hold);
        logic ar_hs;
        arvalid = 1'b1;
        araddr  = {idx, 3'b000};
        while (arvalid) begin
            ar_hs = arready;
            step();
            if (ar_hs) begin
                arvalid = 1'b0;
            end
        end
        while (!rvalid) begin
            step();
        end
        repeat (hold) begin
            step();
            if (!rvalid) begin
                $display("Read data for register %0d vanished while rready was low", idx);
                report_failure();
            end
        end
        data   = rdata;
        rready = 1'b1;
        step();
        rready = 1'b0;
    endtask

    // Poll status until every bit of the mask is set
    task automatic wait_done(input t_status bits, output t_status st);
        t_csr_data rd;
        rd = '0;
        while ((rd[4:0] & bits) != bits) begin
            csr_read(DMA_STATUS, rd, 0);
        end
        st = rd[4:0];
    endtask

    task automatic load_descriptor(input t_mem_addr src, input t_mem_addr dest,
                                   input int unsigned len);
        csr_write(DMA_SRC_ADDR, t_csr_data'(src), 0);
        csr_write(DMA_DEST_ADDR, t_csr_data'(dest), 0);
        csr_write(DMA_LENGTH, t_csr_data'(len), 0);
    endtask

    task automatic check_seq();
        t_csr_data rd;
        csr_read(DMA_SEQ_NUM, rd, 0);
        check_csr("seq_num", rd, t_csr_data'(exp_seq));
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_id_registers();
        t_csr_data rd;
        csr_read(DMA_DFH, rd, 0);
        check_csr("dfh", rd, `DMA_DFH);
        csr_read(DMA_GUID_L, rd, 0);
        check_csr("guid_l", rd, AFU_ID[63:0]);
        csr_read(DMA_GUID_H, rd, 0);
        check_csr("guid_h", rd, AFU_ID[127:64]);
        csr_read(DMA_RSVD_1, rd, 0);
        check_csr("rsvd_1", rd, `DMA_RSVD_1);
        csr_read(DMA_RSVD_2, rd, 0);
        check_csr("rsvd_2", rd, `DMA_RSVD_2);
        csr_read(DMA_TYPE_VERSION, rd, 0);
        check_csr("type_version", rd, `DMA_TYPE_VERSION);
        // Unmapped offsets
        csr_read(5'd12, rd, 0);
        check_csr("offset 12", rd, '0);
        csr_read(5'd31, rd, 0);
        check_csr("offset 31", rd, '0);
    endtask

    task automatic test_descriptor();
        t_csr_data rd;
        load_descriptor(16'h1234, 16'habcd, 16'h0021);
        csr_read(DMA_SRC_ADDR, rd, 0);
        check_csr("src_addr", rd, 64'h1234);
        csr_read(DMA_DEST_ADDR, rd, 0);
        check_csr("dest_addr", rd, 64'habcd);
        csr_read(DMA_LENGTH, rd, 0);
        check_csr("length", rd, 64'h0021);
        csr_read(DMA_STATUS, rd, 0);
        check_csr("status", rd, '0);
        check_seq();
    endtask

    task automatic test_d2h_copy();
        t_status   st;
        t_mem_addr addr;
        t_word     expected [$];
        for (int k = 0; k < len_single; k++) begin
            expected.push_back(ddr_mem[t_mem_addr'(D2H_SRC + k)]);
        end
        load_descriptor(D2H_SRC, D2H_DEST, len_single);
        csr_write(DMA_CONTROL, 64'h1, 0);
        wait_done(5'b00100, st);
        check_status("status after d2h copy", st, 5'b00100);
        exp_seq = exp_seq + 1;
        check_seq();
        for (int k = 0; k < len_single; k++) begin
            addr = t_mem_addr'(D2H_DEST + k);
            check_word($sformatf("host_mem[%h]", addr), host_mem[addr], expected[k]);
        end
    endtask

    task automatic test_both_engines();
        t_status   st;
        t_mem_addr addr;
        t_word     exp_host [$];
        t_word     exp_ddr  [$];
        csr_write(DMA_CONTROL, 64'h4, 0);
        // Each engine reads its own memory at the shared source offset
        for (int k = 0; k < len_pair; k++) begin
            exp_host.push_back(ddr_mem[t_mem_addr'(PAIR_SRC + k)]);
            exp_ddr.push_back(host_mem[t_mem_addr'(PAIR_SRC + k)]);
        end
        load_descriptor(PAIR_SRC, PAIR_DEST, len_pair);
        csr_write(DMA_CONTROL, 64'h3, 0);
        wait_done(5'b01100, st);
        check_status("status after both copies", st, 5'b01100);
        exp_seq = exp_seq + 2;
        check_seq();
        for (int k = 0; k < len_pair; k++) begin
            addr = t_mem_addr'(PAIR_DEST + k);
            check_word($sformatf("host_mem[%h]", addr), host_mem[addr], exp_host[k]);
            check_word($sformatf("ddr_mem[%h]", addr), ddr_mem[addr], exp_ddr[k]);
        end
    endtask

    task automatic test_reject();
        t_status   st;
        t_csr_data rd;
        csr_write(DMA_CONTROL, 64'h4, 0);
        load_descriptor(REJ_SRC, REJ_DEST, REJECT_LEN);
        csr_write(DMA_CONTROL, 64'h1, 0);
        // Second start lands while the first copy runs
        csr_write(DMA_CONTROL, 64'h1, 0);
        wait_done(5'b00100, st);
        check_status("status after reject", st, 5'b10100);
        exp_seq = exp_seq + 1;
        check_seq();
        // Clear drops done and reject together
        csr_write(DMA_CONTROL, 64'h4, 0);
        csr_read(DMA_STATUS, rd, 0);
        check_status("status after clear", rd[4:0], 5'b00000);
    endtask

    task automatic test_zero_length();
        t_status     st;
        t_csr_data   rd;
        int unsigned host_before;
        int unsigned ddr_before;
        host_before = host_wr_count;
        ddr_before  = ddr_wr_count;
        csr_write(DMA_LENGTH, 64'h0, 0);
        csr_write(DMA_CONTROL, 64'h2, 0);
        wait_done(5'b01000, st);
        check_status("status after empty copy", st, 5'b01000);
        exp_seq = exp_seq + 1;
        check_seq();
        if (host_wr_count != host_before || ddr_wr_count != ddr_before) begin
            $display("An empty copy wrote to memory: %0d host and %0d DDR words",
                     host_wr_count - host_before, ddr_wr_count - ddr_before);
            report_failure();
        end
        // Slow bready and rready
        csr_write(DMA_DEST_ADDR, 64'h7a5c, 6);
        csr_read(DMA_DEST_ADDR, rd, 6);
        check_csr("dest_addr after stall", rd, 64'h7a5c);
        csr_read(DMA_STATUS, rd, 5);
        check_status("status after stall", rd[4:0], 5'b01000);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int unsigned limit;
        void'($urandom(32'ha252));
        reset_n = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        // Random contents mixed with the full address
        for (int i = 0; i < 65536; i++) begin
            host_mem[i] = {$urandom(), $urandom()} ^ t_word'(i);
            ddr_mem[i]  = {$urandom(), $urandom()} ^ (t_word'(i) << 16);
        end
        len_single = 1 + $urandom() % 48;
        len_pair   = 1 + $urandom() % 32;
        limit = 200 * CSR_ACCESSES + 4 * (len_single + len_pair + REJECT_LEN) + 500;
        fork
            watchdog(limit);
        join_none
        repeat (3) @(posedge clk);
        #0.5;
        reset_n = 1'b1;
        test_id_registers();
        test_descriptor();
        test_d2h_copy();
        test_both_engines();
        test_reject();
        test_zero_length();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: dma_mover.f
+incdir+verilog
verilog/dma_csr_pkg.sv
verilog/dma_xfer_pkg.sv
verilog/dma_engine_if.sv
verilog/dma_csr_mgr.sv
verilog/dma_copy_engine.sv
verilog/dma_status_merge.sv
verilog/dma_mover_top.sv
tests/tb_dma_mover.sv

// File: Makefile
# Verilator build and run of the DMA mover testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_dma_mover
FILELIST  = dma_mover.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

# The run's exit status is the pass or fail result
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
